// File: hdl/cpuPkg.sv
package cpuPkg;

        ////////////////////////////////////////////////////////////
        // widths
        ////////////////////////////////////////////////////////////
        localparam int dataWidth = 16;          // register and datapath width
        localparam int regCount = 8;
        localparam int idxWidth = $clog2(regCount);

        typedef logic [dataWidth-1:0] word;     // data, addresses, instructions
        typedef logic [idxWidth-1:0] regIdx;

        // instruction fields
        localparam int opHi = 15;
        localparam int opLo = 11;
        localparam int rsLo = 8;                // also LBI destination
        localparam int rtLo = 5;
        localparam int rdLo = 2;                // R format destination
        localparam int iDestLo = 5;             // ADDI and LD destination
        localparam int imm5Hi = 4;
        localparam int imm8Hi = 7;              // LBI and BEQZ
        localparam int imm11Hi = 10;            // J only

        typedef enum logic [4:0] {
                opHalt = 5'b00000,
                opNop  = 5'b00001,
                opJ    = 5'b00100,
                opAddi = 5'b01000,
                opBeqz = 5'b01100,
                opSt   = 5'b10000,
                opLd   = 5'b10001,
                opLbi  = 5'b11000,
                opSub  = 5'b11001,              // rs minus rt
                opAnd  = 5'b11010,
                opAdd  = 5'b11011,
                opXor  = 5'b11100
        } opcode;

        typedef enum logic [1:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluXor
        } aluOp;

        ////////////////////////////////////////////////////////////
        // pipeline registers
        ////////////////////////////////////////////////////////////
        typedef struct packed {
                logic valid;
                word instr;
                word pcNext;                    // address of the following instruction
        } ifIdReg;

        typedef struct packed {
                logic valid;
                opcode op;
                word pcNext;
                regIdx rs;
                regIdx rt;
                word rsVal;
                word rtVal;
                word imm;                       // already sign extended
                regIdx dest;
                aluOp alu;
                logic useImm;
                logic memRead;
                logic memWrite;
                logic regWrite;
                logic branch;
                logic jump;
                logic halt;
                logic illegal;                  // rides along with halt
        } idExReg;

        typedef struct packed {
                logic valid;
                word result;
                word storeData;
                regIdx dest;
                logic memRead;
                logic memWrite;
                logic regWrite;
                logic halt;
                logic illegal;
        } exMemReg;

        typedef struct packed {
                logic valid;
                word result;
                regIdx dest;
                logic regWrite;
                logic halt;
        } memWbReg;

        typedef struct packed {
                word addr;
                word wdata;
                logic write;
        } dmemReq;

        typedef struct packed {
                logic en;
                regIdx dest;
                word value;
        } regWritePort;

endpackage

// File: hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
        input  logic clk,
        input  logic rst,
        input  cpuPkg::ifIdReg ifId,
        input  cpuPkg::regWritePort writeback,
        input  logic flush,
        input  logic memStall,
        output logic loadStall,
        output cpuPkg::idExReg idEx
);
        import cpuPkg::*;

        word instr;
        regIdx rs;
        regIdx rt;
        word rsVal;
        word rtVal;
        logic useRs;
        logic useRt;
        idExReg dec;                            // next ID/EX content

        assign instr = ifId.instr;
        assign rs = instr[rsLo +: idxWidth];
        assign rt = instr[rtLo +: idxWidth];

        registerFile regs (
                .clk(clk),
                .rst(rst),
                .readA(rs),
                .readB(rt),
                .dataA(rsVal),
                .dataB(rtVal),
                .write(writeback)
        );

        ////////////////////////////////////////////////////////////
        // control decode
        ////////////////////////////////////////////////////////////
        always_comb begin
                dec = '0;
                dec.valid = ifId.valid;
                dec.op = opcode'(instr[opHi:opLo]);
                dec.pcNext = ifId.pcNext;
                dec.rs = rs;
                dec.rt = rt;
                dec.rsVal = rsVal;
                dec.rtVal = rtVal;
                dec.imm = word'($signed(instr[imm5Hi:0]));     // imm5 unless overridden
                dec.dest = instr[iDestLo +: idxWidth];
                dec.alu = aluAdd;
                useRs = 1'b1;
                useRt = 1'b0;
                case (dec.op)
                        opAdd, opSub, opAnd, opXor: begin       // R format
                                dec.dest = instr[rdLo +: idxWidth];
                                dec.regWrite = 1'b1;
                                useRt = 1'b1;
                                case (dec.op)
                                        opSub: dec.alu = aluSub;
                                        opAnd: dec.alu = aluAnd;
                                        opXor: dec.alu = aluXor;
                                        default: dec.alu = aluAdd;
                                endcase
                        end
                        opAddi: begin
                                dec.useImm = 1'b1;
                                dec.regWrite = 1'b1;
                        end
                        opLbi: begin
                                dec.imm = word'($signed(instr[imm8Hi:0]));
                                dec.dest = rs;          // LBI writes its rs slot
                                dec.regWrite = 1'b1;
                                useRs = 1'b0;
                        end
                        opLd: begin
                                dec.useImm = 1'b1;
                                dec.memRead = 1'b1;
                                dec.regWrite = 1'b1;
                        end
                        opSt: begin
                                dec.useImm = 1'b1;      // rs + imm5 address
                                dec.memWrite = 1'b1;
                                useRt = 1'b1;           // store data
                        end
                        opBeqz: begin
                                dec.imm = word'($signed(instr[imm8Hi:0]));
                                dec.branch = 1'b1;
                        end
                        opJ: begin
                                dec.imm = word'($signed(instr[imm11Hi:0]));
                                dec.jump = 1'b1;
                                useRs = 1'b0;
                        end
                        opHalt: begin
                                dec.halt = 1'b1;
                                useRs = 1'b0;
                        end
                        opNop: useRs = 1'b0;
                        default: begin                  // unknown opcode halts with error
                                dec.halt = 1'b1;
                                dec.illegal = 1'b1;
                                useRs = 1'b0;
                        end
                endcase
        end

        // load in ID/EX feeding this instruction, one bubble
        assign loadStall = ifId.valid && idEx.valid && idEx.memRead &&
                        ((useRs && idEx.dest == rs) || (useRt && idEx.dest == rt));

        always_ff @(posedge clk) begin
                if (rst) begin
                        idEx.valid <= 1'b0;
                end else if (memStall) begin
                        // held entry would lose the writer leaving WB
                        if (writeback.en && writeback.dest == idEx.rs) begin
                                idEx.rsVal <= writeback.value;
                        end
                        if (writeback.en && writeback.dest == idEx.rt) begin
                                idEx.rtVal <= writeback.value;
                        end
                end else if (flush || loadStall) begin
                        idEx.valid <= 1'b0;     // bubble
                end else begin
                        idEx <= dec;
                end
        end

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
        input  logic clk,
        input  logic rst,
        input  cpuPkg::idExReg idEx,
        output cpuPkg::exMemReg exMemForward,
        input  cpuPkg::regWritePort wbForward,
        input  logic memStall,
        output logic redirect,
        output cpuPkg::word redirectPc,
        output cpuPkg::exMemReg exMem
);
        import cpuPkg::*;

        word opA;
        word opB;
        word aluB;
        word aluOut;
        logic taken;

        // youngest producer wins
        function automatic word pick(input regIdx src, input word fromId);
                if (exMem.valid && exMem.regWrite && exMem.dest == src) begin
                        return exMem.result;
                end
                if (wbForward.en && wbForward.dest == src) begin
                        return wbForward.value;
                end
                return fromId;
        endfunction

        always_comb begin
                opA = pick(idEx.rs, idEx.rsVal);
                opB = pick(idEx.rt, idEx.rtVal);
        end

        ////////////////////////////////////////////////////////////
        // ALU and branch
        ////////////////////////////////////////////////////////////
        assign aluB = idEx.useImm ? idEx.imm : opB;

        always_comb begin
                case (idEx.alu)
                        aluSub: aluOut = opA - aluB;
                        aluAnd: aluOut = opA & aluB;
                        aluXor: aluOut = opA ^ aluB;
                        default: aluOut = opA + aluB;   // also address calc
                endcase
                if (idEx.op == opLbi) begin
                        aluOut = idEx.imm;              // immediate straight through
                end
        end

        assign taken = idEx.jump || (idEx.branch && opA == '0);
        assign redirect = idEx.valid && taken && !memStall;     // wait out a stall
        assign redirectPc = idEx.pcNext + idEx.imm;

        // value heading into EX/MEM
        always_comb begin
                exMemForward.valid = idEx.valid;
                exMemForward.result = aluOut;
                exMemForward.storeData = opB;
                exMemForward.dest = idEx.dest;
                exMemForward.memRead = idEx.memRead;
                exMemForward.memWrite = idEx.memWrite;
                exMemForward.regWrite = idEx.regWrite;
                exMemForward.halt = idEx.halt;
                exMemForward.illegal = idEx.illegal;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        exMem.valid <= 1'b0;
                end else if (!memStall) begin
                        exMem <= exMemForward;
                end
        end

endmodule

// File: hdl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
        input  logic clk,
        input  logic rst,
        input  logic redirect,
        input  cpuPkg::word redirectPc,
        input  logic hold,
        output cpuPkg::word imemAddr,
        input  cpuPkg::word imemData,
        output cpuPkg::ifIdReg ifId
);
        import cpuPkg::*;

        word pc;
        word pcPlus2;
        logic haltSeen;                         // HALT fetched, pc frozen
        logic fetchHalt;

        assign imemAddr = pc;                   // imem answers this cycle
        assign pcPlus2 = pc + word'(2);
        assign fetchHalt = imemData[opHi:opLo] == opHalt;

        always_ff @(posedge clk) begin
                if (rst) begin
                        pc <= '0;
                        haltSeen <= 1'b0;
                        ifId.valid <= 1'b0;
                end else if (redirect) begin
                        pc <= redirectPc;
                        haltSeen <= 1'b0;       // that halt was on the wrong path
                        ifId.valid <= 1'b0;     // squash younger fetch
                end else if (!hold) begin
                        ifId.valid <= !haltSeen;
                        ifId.instr <= imemData;
                        ifId.pcNext <= pcPlus2;
                        if (!haltSeen) begin
                                haltSeen <= fetchHalt;
                                if (!fetchHalt) begin
                                        pc <= pcPlus2;
                                end
                        end
                end
        end

endmodule

// File: hdl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
        input  logic clk,
        input  logic rst,
        input  cpuPkg::exMemReg exMem,
        output logic dmemValid,
        input  logic dmemReady,
        output cpuPkg::dmemReq dmemRequest,
        input  cpuPkg::word dmemReadData,
        output logic memStall,
        output cpuPkg::memWbReg memWb,
        output logic halted,
        output logic err
);
        import cpuPkg::*;

        logic access;
        logic misaligned;                       // never reaches the port
        logic retire;                           // entry moves into MEM/WB
        logic stops;

        assign access = exMem.valid && (exMem.memRead || exMem.memWrite);
        assign misaligned = access && exMem.result[0];
        assign dmemValid = access && !misaligned && !halted;    // quiet after halt
        assign memStall = dmemValid && !dmemReady;
        assign retire = exMem.valid && !memStall && !halted;
        assign stops = exMem.halt || misaligned;

        // EX/MEM holds while waiting so the request stays put
        assign dmemRequest = '{addr: exMem.result, wdata: exMem.storeData,
                        write: exMem.memWrite};

        always_ff @(posedge clk) begin
                if (rst) begin
                        memWb.valid <= 1'b0;
                        halted <= 1'b0;
                        err <= 1'b0;
                end else begin
                        memWb.valid <= retire;  // bubble on stall, no repeated write
                        memWb.result <= exMem.memRead ? dmemReadData : exMem.result;
                        memWb.dest <= exMem.dest;
                        memWb.regWrite <= exMem.regWrite;
                        memWb.halt <= stops;
                        if (retire && stops) begin
                                halted <= 1'b1;
                        end
                        if (retire && (exMem.illegal || misaligned)) begin
                                err <= 1'b1;
                        end
                end
        end

endmodule

// File: hdl/pipelineCpu.sv
`timescale 1ns/1ps

module pipelineCpu (
        input  logic clk,
        input  logic rst,
        output cpuPkg::word imemAddr,
        input  cpuPkg::word imemData,
        output logic dmemValid,
        input  logic dmemReady,
        output cpuPkg::dmemReq dmemRequest,
        input  cpuPkg::word dmemReadData,
        output logic halted,
        output logic err
);
        import cpuPkg::*;

        ifIdReg ifId;
        idExReg idEx;
        exMemReg exMem;
        memWbReg memWb;
        regWritePort writeback;                 // to regfile and execute
        logic redirect;
        word redirectPc;
        logic loadStall;
        logic memStall;

        // a halting entry retires without writing
        assign writeback = '{en: memWb.valid && memWb.regWrite && !memWb.halt,
                        dest: memWb.dest, value: memWb.result};

        ////////////////////////////////////////////////////////////
        // stages
        ////////////////////////////////////////////////////////////
        fetchStage fetch (
                .clk(clk),
                .rst(rst),
                .redirect(redirect),
                .redirectPc(redirectPc),
                .hold(loadStall || memStall),
                .imemAddr(imemAddr),
                .imemData(imemData),
                .ifId(ifId)
        );

        decodeStage decode (
                .clk(clk),
                .rst(rst),
                .ifId(ifId),
                .writeback(writeback),
                .flush(redirect),               // taken branch kills ID/EX
                .memStall(memStall),
                .loadStall(loadStall),
                .idEx(idEx)
        );

        executeStage execute (
                .clk(clk),
                .rst(rst),
                .idEx(idEx),
                .exMemForward(),
                .wbForward(writeback),
                .memStall(memStall),
                .redirect(redirect),
                .redirectPc(redirectPc),
                .exMem(exMem)
        );

        memoryStage memory (
                .clk(clk),
                .rst(rst),
                .exMem(exMem),
                .dmemValid(dmemValid),
                .dmemReady(dmemReady),
                .dmemRequest(dmemRequest),
                .dmemReadData(dmemReadData),
                .memStall(memStall),
                .memWb(memWb),
                .halted(halted),
                .err(err)
        );

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
        input  logic clk,
        input  logic rst,
        input  cpuPkg::regIdx readA,
        input  cpuPkg::regIdx readB,
        output cpuPkg::word dataA,
        output cpuPkg::word dataB,
        input  cpuPkg::regWritePort write
);
        import cpuPkg::*;

        word regs [regCount];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else if (write.en) begin
                        regs[write.dest] <= write.value;
                end
        end

        // write before read, decode sees the retiring value
        assign dataA = (write.en && write.dest == readA) ? write.value : regs[readA];
        assign dataB = (write.en && write.dest == readB) ? write.value : regs[readB];

endmodule

// File: testbench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
        import cpuPkg::*;

        localparam int period = 40;             // ns
        localparam int resetCycles = 8;
        localparam int settleCycles = 12;       // quiet time after halted
        localparam int cyclesPerRow = 200;      // watchdog budget per row
        localparam int rowCount = 9;
        localparam int progMax = 32;
        localparam int storeMax = 8;
        localparam int dataDepth = 32768;       // full 16-bit byte space
        localparam logic [31:0] lfsrSeed = 32'h3361_0d0c;
        localparam word haltInstr = {opHalt, 11'd0};

        logic clk;
        logic rst;
        word imemAddr;
        word imemData;
        logic dmemValid;
        logic dmemReady;
        dmemReq dmemRequest;
        word dmemReadData;
        logic halted;
        logic err;

        // test table
        word progImg [rowCount][progMax];
        int progLen [rowCount];
        logic lfsrMode [rowCount];              // 0 always ready, 1 random ready
        word expAddr [rowCount][storeMax];
        word expData [rowCount][storeMax];
        int expCount [rowCount];
        logic expErr [rowCount];
        int buildRow;

        // memory models and observed stores
        word imem [progMax];
        int curLen;
        word dmem [dataDepth];
        word gotAddr [$];
        word gotData [$];
        logic useLfsr;
        logic [31:0] lfsr;

        pipelineCpu UUT (
                .clk(clk),
                .rst(rst),
                .imemAddr(imemAddr),
                .imemData(imemData),
                .dmemValid(dmemValid),
                .dmemReady(dmemReady),
                .dmemRequest(dmemRequest),
                .dmemReadData(dmemReadData),
                .halted(halted),
                .err(err)
        );

        // past the program end the fetch sees HALT
        assign imemData = (int'(imemAddr[15:1]) < curLen) ? imem[imemAddr[5:1]] : haltInstr;
        assign dmemReadData = dmem[dmemRequest.addr[15:1]];    // same-cycle read

        initial begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        ////////////////////////////////////////////////////////////
        // helpers
        ////////////////////////////////////////////////////////////
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois, right shift
        endfunction

        function automatic word fillValue(input word addr);
                return (word'(addr[15:1]) * 16'h9e37) ^ 16'h5a5a;
        endfunction

        // instruction assembly
        function automatic word rType(input opcode op, input regIdx rs, input regIdx rt,
                        input regIdx rd);
                return {op, rs, rt, rd, 2'b00};
        endfunction

        function automatic word iType(input opcode op, input regIdx rs, input regIdx rt,
                        input logic [4:0] imm);
                return {op, rs, rt, imm};       // rt is dest for ADDI/LD, data for ST
        endfunction

        function automatic word wideType(input opcode op, input regIdx rs, input logic [7:0] imm);
                return {op, rs, imm};           // LBI and BEQZ
        endfunction

        task automatic newRow(input logic lfsrOn, input logic errOn);
                buildRow++;
                progLen[buildRow] = 0;
                expCount[buildRow] = 0;
                lfsrMode[buildRow] = lfsrOn;
                expErr[buildRow] = errOn;
        endtask

        task automatic emit(input word instr);
                progImg[buildRow][progLen[buildRow]] = instr;
                progLen[buildRow]++;
        endtask

        task automatic expectStore(input word addr, input word data);
                expAddr[buildRow][expCount[buildRow]] = addr;
                expData[buildRow][expCount[buildRow]] = data;
                expCount[buildRow]++;
        endtask

        ////////////////////////////////////////////////////////////
        // programs
        ////////////////////////////////////////////////////////////
        task automatic aluChainRow(input logic lfsrOn);
                newRow(lfsrOn, 1'b0);
                emit(wideType(opLbi, 3'd1, 8'h9c));             // r1 = ff9c
                emit(wideType(opLbi, 3'd2, 8'h25));             // r2 = 0025
                emit(rType(opAdd, 3'd1, 3'd2, 3'd3));           // r3 = ffc1
                emit(rType(opSub, 3'd2, 3'd3, 3'd4));           // r4 = 0064
                emit(rType(opAnd, 3'd4, 3'd3, 3'd5));           // r5 = 0040
                emit(rType(opXor, 3'd5, 3'd1, 3'd6));           // r6 = ffdc
                emit(iType(opAddi, 3'd6, 3'd7, 5'h1b));         // r7 = r6 - 5
                emit(iType(opSt, 3'd0, 3'd7, 5'd8));
                emit(iType(opSt, 3'd0, 3'd6, 5'd6));
                emit(iType(opSt, 3'd0, 3'd5, 5'd4));
                emit(iType(opSt, 3'd0, 3'd4, 5'd2));
                emit(iType(opSt, 3'd0, 3'd3, 5'd0));
                emit(iType(opSt, 3'd0, 3'd1, 5'd10));
                emit(haltInstr);
                expectStore(16'h0008, 16'hffd7);
                expectStore(16'h0006, 16'hffdc);
                expectStore(16'h0004, 16'h0040);
                expectStore(16'h0002, 16'h0064);
                expectStore(16'h0000, 16'hffc1);
                expectStore(16'h000a, 16'hff9c);
        endtask

        task automatic loadUseRow(input logic lfsrOn);
                newRow(lfsrOn, 1'b0);
                emit(wideType(opLbi, 3'd1, 8'hc9));             // r1 = ffc9
                emit(wideType(opLbi, 3'd2, 8'h20));             // base 0x20
                emit(iType(opSt, 3'd2, 3'd1, 5'd0));
                emit(iType(opLd, 3'd2, 3'd3, 5'd0));
                emit(rType(opAdd, 3'd3, 3'd3, 3'd4));           // uses load at once
                emit(iType(opSt, 3'd2, 3'd4, 5'd2));
                emit(iType(opLd, 3'd2, 3'd5, 5'd4));            // untouched word
                emit(iType(opSt, 3'd2, 3'd5, 5'd6));            // load feeds store data
                emit(haltInstr);
                expectStore(16'h0020, 16'hffc9);
                expectStore(16'h0022, 16'hff92);
                expectStore(16'h0026, fillValue(16'h0024));
        endtask

        task automatic branchRow(input logic lfsrOn);
                newRow(lfsrOn, 1'b0);
                emit(wideType(opLbi, 3'd2, 8'h40));             // 0: base
                emit(wideType(opLbi, 3'd3, 8'h11));             // 2
                emit(wideType(opLbi, 3'd1, 8'h00));             // 4
                emit(wideType(opBeqz, 3'd1, 8'd2));             // 6: taken to 10
                emit(iType(opSt, 3'd2, 3'd3, 5'd0));            // 8: skipped
                emit({opJ, 11'd2});                             // 10: to 14
                emit(iType(opSt, 3'd2, 3'd3, 5'd2));            // 12: skipped
                emit(wideType(opBeqz, 3'd3, 8'd2));             // 14: not taken
                emit(iType(opSt, 3'd2, 3'd3, 5'd4));            // 16
                emit(iType(opSt, 3'd2, 3'd1, 5'd6));            // 18
                emit(haltInstr);
                expectStore(16'h0044, 16'h0011);
                expectStore(16'h0046, 16'h0000);
        endtask

        task automatic buildTable();
                buildRow = -1;
                aluChainRow(1'b0);
                loadUseRow(1'b0);
                branchRow(1'b0);
                aluChainRow(1'b1);                              // same rows under back-pressure
                loadUseRow(1'b1);
                branchRow(1'b1);
                newRow(1'b0, 1'b0);                             // nothing after HALT
                emit(wideType(opLbi, 3'd1, 8'h7e));
                emit(iType(opSt, 3'd0, 3'd1, 5'd12));
                emit(haltInstr);
                emit(iType(opSt, 3'd0, 3'd1, 5'd14));
                emit(iType(opSt, 3'd0, 3'd1, 5'd0));
                expectStore(16'h000c, 16'h007e);
                newRow(1'b0, 1'b1);                             // misaligned store
                emit(wideType(opLbi, 3'd1, 8'h33));
                emit(iType(opSt, 3'd0, 3'd1, 5'd14));
                emit(wideType(opLbi, 3'd2, 8'h05));
                emit(iType(opSt, 3'd2, 3'd1, 5'd0));            // address 5
                emit(iType(opSt, 3'd0, 3'd1, 5'd0));
                emit(haltInstr);
                expectStore(16'h000e, 16'h0033);
                newRow(1'b0, 1'b1);                             // illegal opcode
                emit(wideType(opLbi, 3'd1, 8'h44));
                emit(iType(opSt, 3'd0, 3'd1, 5'd8));
                emit({5'b11111, 11'd0});                        // no such opcode
                emit(iType(opSt, 3'd0, 3'd1, 5'd10));
                emit(haltInstr);
                expectStore(16'h0008, 16'h0044);
        endtask

        ////////////////////////////////////////////////////////////
        // checking
        ////////////////////////////////////////////////////////////
        task automatic checkValue(input string what, input word got, input word expected);
                if (got !== expected) begin
                        $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got,
                                        expected);
                        $display("tests failed");
                        $fatal(1, "stopping at the first mismatch");
                end
        endtask

        task automatic startRow(input int row);
                rst = 1'b1;
                useLfsr = lfsrMode[row];
                curLen = progLen[row];
                for (int i = 0; i < progLen[row]; i++) begin
                        imem[i] = progImg[row][i];
                end
                for (int i = 0; i < dataDepth; i++) begin
                        dmem[i] = fillValue(word'(i << 1));
                end
                gotAddr.delete();
                gotData.delete();
                repeat (resetCycles) @(negedge clk);
                rst = 1'b0;
        endtask

        task automatic checkRow(input int row);
                int n;
                n = (gotAddr.size() < expCount[row]) ? gotAddr.size() : expCount[row];
                for (int k = 0; k < n; k++) begin
                        checkValue($sformatf("row %0d store %0d address", row, k), gotAddr[k],
                                        expAddr[row][k]);
                        checkValue($sformatf("row %0d store %0d data", row, k), gotData[k],
                                        expData[row][k]);
                end
                checkValue($sformatf("row %0d store count", row), word'(gotAddr.size()),
                                word'(expCount[row]));
                checkValue($sformatf("row %0d err", row), word'(err), word'(expErr[row]));
                checkValue($sformatf("row %0d halted", row), word'(halted), word'(1));
        endtask

        // ready for the coming edge, then log what transfers on it
        always @(negedge clk) begin
                if (useLfsr) begin
                        lfsr = lfsrNext(lfsr);
                        dmemReady = lfsr[0];
                end else begin
                        dmemReady = 1'b1;
                end
                if (!rst && dmemValid === 1'b1 && dmemReady && dmemRequest.write) begin
                        gotAddr.push_back(dmemRequest.addr);
                        gotData.push_back(dmemRequest.wdata);
                        dmem[dmemRequest.addr[15:1]] = dmemRequest.wdata;
                end
        end

        initial begin
                repeat (rowCount * cyclesPerRow) @(posedge clk);
                $display("ERROR: the processor never halted within %0d cycles",
                                rowCount * cyclesPerRow);
                $display("tests failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                rst = 1'b1;
                dmemReady = 1'b1;
                useLfsr = 1'b0;
                lfsr = lfsrSeed;
                curLen = 0;
                buildTable();
                for (int row = 0; row < rowCount; row++) begin
                        startRow(row);
                        while (halted !== 1'b1) @(negedge clk);
                        repeat (settleCycles) @(negedge clk);   // late requests would show here
                        checkRow(row);
                end
                $display("all tests passed");
                $finish;
        end

endmodule

// File: testbench/cpu_properties.sv
`timescale 1ns/1ps

module cpuProperties (
        input logic clk,
        input logic rst,
        input logic dmemValid,
        input logic dmemReady,
        input cpuPkg::dmemReq dmemRequest,
        input logic halted,
        input logic err
);

        // waiting request holds still
        requestHeld: assert property (@(posedge clk) disable iff (rst)
                        dmemValid && !dmemReady |=> dmemValid && $stable(dmemRequest))
                else $error("data memory request changed while waiting for ready");

        quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
                        halted |-> !dmemValid)
                else $error("data memory request raised after halt");

        errHalts: assert property (@(posedge clk) disable iff (rst)
                        err |-> halted)
                else $error("err high while not halted");

endmodule

bind pipelineCpu cpuProperties props (
        .clk(clk),
        .rst(rst),
        .dmemValid(dmemValid),
        .dmemReady(dmemReady),
        .dmemRequest(dmemRequest),
        .halted(halted),
        .err(err)
);

// File: verilog.f
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipelineCpu.sv
testbench/cpu_properties.sv
testbench/cpuTb.sv
